//--- logic/board_pkg.sv
/*
  Shared constants and types for the board glue around the SoC.
  Modules refer to everything here by scoped name, never by import.
  The top level takes its parameter defaults from these values.
*/

`default_nettype none

package board_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // flash media selection
  ////////////////////////////////////////////////////////////////////////////

  // which board pins the SPI host drives
  typedef enum logic {
    flash_sd   = 1'b0,
    flash_qspi = 1'b1
  } flash_media_e;

  ////////////////////////////////////////////////////////////////////////////
  // default timing
  ////////////////////////////////////////////////////////////////////////////

  // flops in the reset release chain
  localparam int RstSyncStages = 2;

  // soc_clk cycles per rtc half period, 50 MHz down to 1 MHz
  localparam int RtcHalfDiv = 25;

  ////////////////////////////////////////////////////////////////////////////
  // pin and bus widths
  ////////////////////////////////////////////////////////////////////////////

  // fan switch setting, also the pwm counter width
  localparam int FanSettingWidth = 4;

  // spi host side
  localparam int SpiCsWidth   = 2;
  localparam int SpiDataWidth = 4;

  // sd slot data pins
  localparam int SdDataWidth = 4;

endpackage

`default_nettype wire

//--- logic/board_reset_sync.sv
/*
  Combines the board reset and the debug soft reset into one SoC reset.
  Either source clears the reset chain at once, without a clock.
  Release is synchronous to soc_clk, SyncStages edges after both go idle.
*/

`timescale 1ns/1ps
`default_nettype none

module board_reset_sync #(
  parameter int SyncStages = board_pkg::RstSyncStages
) (
  input  logic soc_clk,
  input  logic rst_n,
  input  logic soft_reset_i,
  output logic soc_rst_no
);

  // combined asynchronous clear, low while any source is active
  logic comb_rst_n;

  // release chain, ones shift in from bit 0
  logic [SyncStages-1:0] sync_q;

  assign comb_rst_n = rst_n & ~soft_reset_i;

  ////////////////////////////////////////////////////////////////////////////
  // synchronizer chain
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge soc_clk, negedge comb_rst_n) begin
    if (!comb_rst_n) begin
      sync_q <= '0;
    end else if (SyncStages == 1) begin
      // single stage, nothing to shift through
      sync_q <= '1;
    end else begin
      sync_q <= {sync_q[SyncStages-2:0], 1'b1};
    end
  end

  // last stage is the soc reset
  assign soc_rst_no = sync_q[SyncStages-1];

  ////////////////////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////////////////////

  // board reset must hold the soc in reset regardless of the chain
  assert property (@(posedge soc_clk) !rst_n |-> !soc_rst_no)
    else $error("soc reset released while board reset active");

endmodule

`default_nettype wire

//--- logic/fan_pwm_ctrl.sv
/*
  Fan PWM from the board switches.
  A free-running counter is compared with the setting, the output is
  high for setting cycles out of every 2**SettingWidth, one cycle late.
*/

`timescale 1ns/1ps
`default_nettype none

module fan_pwm_ctrl #(
  parameter int SettingWidth = board_pkg::FanSettingWidth
) (
  input  logic                    soc_clk,
  input  logic                    rst_n,
  input  logic [SettingWidth-1:0] pwm_setting_i,
  output logic                    fan_pwm_o
);

  // wraps every 2**SettingWidth cycles
  logic [SettingWidth-1:0] pwm_cnt_q;

  // compare result before the output flop
  logic pwm_on;
  logic pwm_q;

  ////////////////////////////////////////////////////////////////////////////
  // pwm counter
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge soc_clk, negedge rst_n) begin
    if (!rst_n) begin
      pwm_cnt_q <= '0;
    end else begin
      // natural wrap at all ones
      pwm_cnt_q <= pwm_cnt_q + 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // compare and output
  ////////////////////////////////////////////////////////////////////////////

  // 0 keeps the fan off, all ones is the highest duty
  assign pwm_on = (pwm_cnt_q < pwm_setting_i);

  always_ff @(posedge soc_clk, negedge rst_n) begin
    if (!rst_n) begin
      pwm_q <= 1'b0;
    end else begin
      pwm_q <= pwm_on;
    end
  end

  // registered so the pin sees no compare glitches
  assign fan_pwm_o = pwm_q;

endmodule

`default_nettype wire

//--- logic/flash_pin_adapter.sv
/*
  Maps the SoC SPI host pins onto the board flash pins.
  Media selects an SD slot in SPI mode or a QSPI flash.
  Purely combinational; the unused side idles high.
*/

`timescale 1ns/1ps
`default_nettype none

module flash_pin_adapter #(
  parameter board_pkg::flash_media_e Media = board_pkg::flash_sd
) (
  // spi host side
  input  logic                              spih_sck_i,
  input  logic                              spih_sck_en_i,
  input  logic [board_pkg::SpiCsWidth-1:0]   spih_csb_i,
  input  logic [board_pkg::SpiCsWidth-1:0]   spih_csb_en_i,
  input  logic [board_pkg::SpiDataWidth-1:0] spih_sd_i,
  input  logic [board_pkg::SpiDataWidth-1:0] spih_sd_en_i,
  output logic [board_pkg::SpiDataWidth-1:0] spih_sd_o,
  // sd slot
  output logic                              sd_sclk_o,
  output logic                              sd_cmd_o,
  output logic [board_pkg::SdDataWidth-1:0]  sd_dat_o,
  output logic                              sd_reset_o,
  input  logic                              sd_dat0_i,
  // qspi flash
  output logic                              qspi_clk_o,
  output logic                              qspi_cs_b_o,
  input  logic                              qspi_dq0_i
);

  // host clock, idles high when the host does not drive it
  logic sck_gated;

  assign sck_gated = spih_sck_en_i ? spih_sck_i : 1'b1;

  ////////////////////////////////////////////////////////////////////////////
  // pin mapping
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    // idle levels, sd reset low keeps the card powered
    sd_sclk_o   = 1'b1;
    sd_cmd_o    = 1'b1;
    sd_dat_o    = '1;
    sd_reset_o  = 1'b0;
    qspi_clk_o  = 1'b1;
    qspi_cs_b_o = 1'b1;
    spih_sd_o   = '0;
    case (Media)
      board_pkg::flash_sd: begin
        sd_sclk_o = sck_gated;
        // cs0 on DAT3
        sd_dat_o[3] = spih_csb_en_i[0] ? spih_csb_i[0] : 1'b1;
        // mosi on CMD
        sd_cmd_o = spih_sd_en_i[0] ? spih_sd_i[0] : 1'b1;
        // DAT1/DAT2 unused in spi mode, left high from the defaults
        // miso from DAT0 back to host line 1
        spih_sd_o[1] = sd_dat0_i;
      end
      board_pkg::flash_qspi: begin
        qspi_clk_o = sck_gated;
        // flash cs follows the host with no enable
        qspi_cs_b_o  = spih_csb_i[0];
        spih_sd_o[1] = qspi_dq0_i;
      end
      default: begin
      end
    endcase
  end

  // card power must stay on whichever media is selected
  always_comb begin
    assert (sd_reset_o == 1'b0)
      else $error("sd reset driven high");
  end

endmodule

`default_nettype wire

//--- logic/fpga_board_top.sv
/*
  Board-level glue of the FPGA SoC wrapper, the SoC itself sits outside.
  Holds reset combining, the RTC divider, fan PWM and the flash pin mapping.
  The SPI host pins are top-level ports facing the SoC.
*/

`timescale 1ns/1ps
`default_nettype none

module fpga_board_top #(
  parameter board_pkg::flash_media_e FlashMedia = board_pkg::flash_sd,
  parameter int RstStages = board_pkg::RstSyncStages,
  parameter int RtcDiv    = board_pkg::RtcHalfDiv,
  parameter int FanWidth  = board_pkg::FanSettingWidth
) (
  input  logic                              soc_clk,
  input  logic                              rst_n,
  input  logic                              soft_reset_i,
  // fan
  input  logic [FanWidth-1:0]               fan_sw_i,
  output logic                              fan_pwm_o,
  // spi host from the soc
  input  logic                              spih_sck_i,
  input  logic                              spih_sck_en_i,
  input  logic [board_pkg::SpiCsWidth-1:0]   spih_csb_i,
  input  logic [board_pkg::SpiCsWidth-1:0]   spih_csb_en_i,
  input  logic [board_pkg::SpiDataWidth-1:0] spih_sd_i,
  input  logic [board_pkg::SpiDataWidth-1:0] spih_sd_en_i,
  output logic [board_pkg::SpiDataWidth-1:0] spih_sd_o,
  // sd slot
  output logic                              sd_sclk_o,
  output logic                              sd_cmd_o,
  output logic [board_pkg::SdDataWidth-1:0]  sd_dat_o,
  output logic                              sd_reset_o,
  input  logic                              sd_dat0_i,
  // qspi flash
  output logic                              qspi_clk_o,
  output logic                              qspi_cs_b_o,
  input  logic                              qspi_dq0_i,
  // to the soc
  output logic                              soc_rst_no,
  output logic                              rtc_o
);

  ////////////////////////////////////////////////////////////////////////////
  // reset
  ////////////////////////////////////////////////////////////////////////////

  // soc_rst_no doubles as the internal reset of the blocks below
  board_reset_sync #(
    .SyncStages   ( RstStages    )
  ) i_board_reset_sync (
    .soc_clk      ( soc_clk      ),
    .rst_n        ( rst_n        ),
    .soft_reset_i ( soft_reset_i ),
    .soc_rst_no   ( soc_rst_no   )
  );

  ////////////////////////////////////////////////////////////////////////////
  // rtc and fan
  ////////////////////////////////////////////////////////////////////////////

  rtc_clock_divider #(
    .HalfDiv ( RtcDiv     )
  ) i_rtc_clock_divider (
    .soc_clk ( soc_clk    ),
    .rst_n   ( soc_rst_no ),
    .rtc_o   ( rtc_o      )
  );

  fan_pwm_ctrl #(
    .SettingWidth  ( FanWidth   )
  ) i_fan_pwm_ctrl (
    .soc_clk       ( soc_clk    ),
    .rst_n         ( soc_rst_no ),
    .pwm_setting_i ( fan_sw_i   ),
    .fan_pwm_o     ( fan_pwm_o  )
  );

  ////////////////////////////////////////////////////////////////////////////
  // flash pins
  ////////////////////////////////////////////////////////////////////////////

  // media fixed at build time
  flash_pin_adapter #(
    .Media         ( FlashMedia    )
  ) i_flash_pin_adapter (
    .spih_sck_i    ( spih_sck_i    ),
    .spih_sck_en_i ( spih_sck_en_i ),
    .spih_csb_i    ( spih_csb_i    ),
    .spih_csb_en_i ( spih_csb_en_i ),
    .spih_sd_i     ( spih_sd_i     ),
    .spih_sd_en_i  ( spih_sd_en_i  ),
    .spih_sd_o     ( spih_sd_o     ),
    .sd_sclk_o     ( sd_sclk_o     ),
    .sd_cmd_o      ( sd_cmd_o      ),
    .sd_dat_o      ( sd_dat_o      ),
    .sd_reset_o    ( sd_reset_o    ),
    .sd_dat0_i     ( sd_dat0_i     ),
    .qspi_clk_o    ( qspi_clk_o    ),
    .qspi_cs_b_o   ( qspi_cs_b_o   ),
    .qspi_dq0_i    ( qspi_dq0_i    )
  );

endmodule

`default_nettype wire

//--- logic/rtc_clock_divider.sv
/*
  Divides soc_clk down to the real-time clock square wave of the SoC.
  The output toggles every HalfDiv cycles, so its period is 2*HalfDiv.
  Held low while the SoC reset is active.
*/

`timescale 1ns/1ps
`default_nettype none

module rtc_clock_divider #(
  parameter int HalfDiv = board_pkg::RtcHalfDiv
) (
  input  logic soc_clk,
  input  logic rst_n,
  output logic rtc_o
);

  // counter wide enough for HalfDiv-1, at least one bit
  localparam int CntWidth = (HalfDiv > 1) ? $clog2(HalfDiv) : 1;
  localparam logic [CntWidth-1:0] CntLast = CntWidth'(HalfDiv - 1);

  logic [CntWidth-1:0] cnt_q;
  logic [CntWidth-1:0] cnt_d;
  logic                rtc_q;
  logic                rtc_d;

  ////////////////////////////////////////////////////////////////////////////
  // half period counter
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    cnt_d = cnt_q + 1'b1;
    rtc_d = rtc_q;
    // end of half period, wrap and flip the clock
    if (cnt_q == CntLast) begin
      cnt_d = '0;
      rtc_d = ~rtc_q;
    end
  end

  always_ff @(posedge soc_clk, negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
      rtc_q <= 1'b0;
    end else begin
      cnt_q <= cnt_d;
      rtc_q <= rtc_d;
    end
  end

  // straight from the flop, no glitches on the rtc
  assign rtc_o = rtc_q;

  // counter stays inside one half period
  assert property (@(posedge soc_clk) disable iff (!rst_n) cnt_q <= CntLast)
    else $error("rtc counter beyond half period");

endmodule

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
# builds the board glue testbench with verilator and runs it
set -u

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
build_log=build.log
sim_log=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f src.f --top-module tb_board_top \
  -Mdir "$build_dir" -o sim_board > "$build_log" 2>&1
status=$?
if [ "$status" -ne 0 ]; then
  cat "$build_log"
  echo "verilator build failed with status $status"
  exit 1
fi

"./$build_dir/sim_board" > "$sim_log" 2>&1
status=$?
cat "$sim_log"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^Simulation completed successfully$" "$sim_log"; then
  exit 0
fi
echo "pass message not found in $sim_log"
exit 1

//--- src.f
+incdir+testbench
logic/board_pkg.sv
logic/board_reset_sync.sv
logic/rtc_clock_divider.sv
logic/fan_pwm_ctrl.sv
logic/flash_pin_adapter.sv
logic/fpga_board_top.sv
testbench/tb_board_top.sv

//--- testbench/tb_board_tests.svh
/*
  Directed test tasks of the board glue testbench.
  Included inside tb_board_top, uses its signals and compare tasks.
*/

`default_nettype none

// call right after a release driven on a rising edge
task automatic wait_release(output int cycles);
  cycles = 0;
  @(negedge soc_clk);
  while (soc_rst_no !== 1'b1 && cycles < 20) begin
    @(negedge soc_clk);
    cycles++;
  end
  if (soc_rst_no !== 1'b1) begin
    note_failure("soc reset was never released");
  end
endtask

// negedges until rtc_o reaches level, at most one period
task automatic count_rtc_until(input logic level, output int n);
  n = 0;
  while (rtc_o !== level && n <= 2 * board_pkg::RtcHalfDiv) begin
    @(negedge soc_clk);
    n++;
  end
  if (rtc_o !== level) begin
    note_failure("rtc_o stopped toggling");
  end
endtask

// new random host pin values on the next edge
task automatic drive_host();
  @(posedge soc_clk);
  spih_sck_i    <= 1'($urandom);
  spih_sck_en_i <= 1'($urandom);
  spih_csb_i    <= CsW'($urandom);
  spih_csb_en_i <= CsW'($urandom);
  spih_sd_i     <= DataW'($urandom);
  spih_sd_en_i  <= DataW'($urandom);
  sd_dat0_i     <= 1'($urandom);
  qspi_dq0_i    <= 1'($urandom);
endtask

////////////////////////////////////////////////////////////////////////////
// reset and rtc
////////////////////////////////////////////////////////////////////////////

task automatic test_reset_release();
  int err0;
  int cycles;
  err0 = errors;
  @(negedge soc_clk);
  check_bit("rst_held", 1'b0, soc_rst_no);
  check_bit("rtc_in_reset", 1'b0, rtc_o);
  check_bit("fan_in_reset", 1'b0, fan_pwm_o);
  @(posedge soc_clk);
  rst_n <= 1'b1;
  wait_release(cycles);
  check_count("rst_release", board_pkg::RstSyncStages, cycles);
  // soft reset clears before the next edge
  @(posedge soc_clk);
  soft_reset_i <= 1'b1;
  #1;
  check_bit("soft_rst_assert", 1'b0, soc_rst_no);
  repeat (3) @(posedge soc_clk);
  soft_reset_i <= 1'b0;
  wait_release(cycles);
  check_count("soft_rst_release", board_pkg::RstSyncStages, cycles);
  finish_test("reset_release", err0);
endtask

task automatic test_rtc();
  int err0;
  int cycles;
  int hi;
  int lo;
  err0 = errors;
  // let the rtc go high first, so the soft reset has something to clear
  count_rtc_until(1'b1, hi);
  @(posedge soc_clk);
  soft_reset_i <= 1'b1;
  #1;
  check_bit("rtc_in_reset", 1'b0, rtc_o);
  @(posedge soc_clk);
  soft_reset_i <= 1'b0;
  wait_release(cycles);
  // counted from the edge that released the soc
  count_rtc_until(1'b1, hi);
  check_count("rtc_first_rise", board_pkg::RtcHalfDiv, hi);
  repeat (RtcPeriods) begin
    count_rtc_until(1'b0, hi);
    count_rtc_until(1'b1, lo);
    check_count("rtc_high_time", board_pkg::RtcHalfDiv, hi);
    check_count("rtc_period", 2 * board_pkg::RtcHalfDiv, hi + lo);
  end
  finish_test("rtc", err0);
endtask

////////////////////////////////////////////////////////////////////////////
// fan and flash pins
////////////////////////////////////////////////////////////////////////////

task automatic test_fan_pwm();
  logic [FanW-1:0] settings [6];
  int err0;
  int i;
  int c;
  int high;
  err0 = errors;
  // off and full scale, then random
  settings[0] = '0;
  settings[1] = '1;
  for (i = 2; i < 6; i++) begin
    settings[i] = FanW'($urandom);
  end
  for (i = 0; i < 6; i++) begin
    @(posedge soc_clk);
    fan_sw_i <= settings[i];
    high = 0;
    for (c = 0; c < 32; c++) begin
      @(negedge soc_clk);
      // first half settles through the output flop
      if (c >= 16 && fan_pwm_o === 1'b1) begin
        high++;
      end
    end
    check_count($sformatf("fan_duty_%0d", settings[i]), int'(settings[i]), high);
  end
  finish_test("fan_pwm", err0);
endtask

task automatic test_sd_pins();
  pin_set_t         exp_pins;
  logic [DataW-1:0] exp_data;
  int               err0;
  int               i;
  err0 = errors;
  for (i = 0; i < PinIters; i++) begin
    drive_host();
    @(negedge soc_clk);
    // sclk, cmd, dat3 from the host, dat2..0 high, reset low, qspi idle
    exp_pins = {spih_sck_en_i ? spih_sck_i : 1'b1,
                spih_sd_en_i[0] ? spih_sd_i[0] : 1'b1,
                spih_csb_en_i[0] ? spih_csb_i[0] : 1'b1,
                3'b111, 1'b0, 2'b11};
    exp_data    = '0;
    exp_data[1] = sd_dat0_i;
    check_pins("sd_pins", board_pkg::flash_sd, exp_pins,
               {sd_sclk_o, sd_cmd_o, sd_dat_o, sd_reset_o, qspi_clk_o, qspi_cs_b_o});
    check_data("sd_miso", exp_data, spih_sd_o);
  end
  finish_test("sd_pins", err0);
endtask

task automatic test_qspi_pins();
  pin_set_t         exp_pins;
  logic [DataW-1:0] exp_data;
  int               err0;
  int               i;
  err0 = errors;
  for (i = 0; i < PinIters; i++) begin
    drive_host();
    @(negedge soc_clk);
    // sd side idle, chip select passes without its enable
    exp_pins = {6'b111111, 1'b0,
                spih_sck_en_i ? spih_sck_i : 1'b1,
                spih_csb_i[0]};
    exp_data    = '0;
    exp_data[1] = qspi_dq0_i;
    check_pins("qspi_pins", board_pkg::flash_qspi, exp_pins,
               {qs_sd_sclk, qs_sd_cmd, qs_sd_dat, qs_sd_reset, qs_qspi_clk, qs_qspi_cs_b});
    check_data("qspi_miso", exp_data, qs_spih_sd);
  end
  finish_test("qspi_pins", err0);
endtask

`default_nettype wire

//--- testbench/tb_board_top.sv
/*
  Directed testbench for the board glue; the testbench plays the SoC.
  uut maps the SPI host onto the SD slot, uut_qspi onto the QSPI flash.
  Test tasks come from the included tb_board_tests.svh.
*/

`timescale 1ns/1ps
`default_nettype none

module tb_board_top;

  localparam int ClkPeriod  = 8;
  localparam int DataW      = board_pkg::SpiDataWidth;
  localparam int CsW        = board_pkg::SpiCsWidth;
  localparam int FanW       = board_pkg::FanSettingWidth;
  localparam int PinIters   = 20;
  localparam int RtcPeriods = 3;
  // reset, release, rtc, fan and pin tests back to back
  localparam int RunCycles  = 16 + 30 + 2 * board_pkg::RtcHalfDiv * (RtcPeriods + 2) + 10
                              + 6 * 34 + 2 * (PinIters + 1);

  // sd pins, then qspi pins
  typedef logic [8:0] pin_set_t;

  logic             soc_clk;
  logic             rst_n;
  logic             soft_reset_i;
  logic [FanW-1:0]  fan_sw_i;
  logic             spih_sck_i;
  logic             spih_sck_en_i;
  logic [CsW-1:0]   spih_csb_i;
  logic [CsW-1:0]   spih_csb_en_i;
  logic [DataW-1:0] spih_sd_i;
  logic [DataW-1:0] spih_sd_en_i;
  logic             sd_dat0_i;
  logic             qspi_dq0_i;

  // sd build outputs
  logic             fan_pwm_o;
  logic [DataW-1:0] spih_sd_o;
  logic             sd_sclk_o;
  logic             sd_cmd_o;
  logic [3:0]       sd_dat_o;
  logic             sd_reset_o;
  logic             qspi_clk_o;
  logic             qspi_cs_b_o;
  logic             soc_rst_no;
  logic             rtc_o;

  // qspi build outputs
  logic [DataW-1:0] qs_spih_sd;
  logic             qs_sd_sclk;
  logic             qs_sd_cmd;
  logic [3:0]       qs_sd_dat;
  logic             qs_sd_reset;
  logic             qs_qspi_clk;
  logic             qs_qspi_cs_b;

  int errors = 0;
  int checks = 0;
  int tests  = 0;

  fpga_board_top #(.FlashMedia(board_pkg::flash_sd)) uut (.*);

  // same inputs, every output on its own wire
  fpga_board_top #(.FlashMedia(board_pkg::flash_qspi)) uut_qspi (
    .*,
    .fan_pwm_o   (),
    .spih_sd_o   (qs_spih_sd),
    .sd_sclk_o   (qs_sd_sclk),
    .sd_cmd_o    (qs_sd_cmd),
    .sd_dat_o    (qs_sd_dat),
    .sd_reset_o  (qs_sd_reset),
    .qspi_clk_o  (qs_qspi_clk),
    .qspi_cs_b_o (qs_qspi_cs_b),
    .soc_rst_no  (),
    .rtc_o       ()
  );

  ////////////////////////////////////////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_bit(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Mismatch %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic check_data(input string name, input logic [DataW-1:0] exp,
                            input logic [DataW-1:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Mismatch %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    checks++;
    if (act != exp) begin
      errors++;
      $display("Mismatch %s: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  task automatic check_pins(input string name, input board_pkg::flash_media_e media,
                            input pin_set_t exp, input pin_set_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Mismatch %s (%s): expected %b, actual %b", name, media.name(), exp, act);
    end
  endtask

  task automatic note_failure(input string msg);
    errors++;
    $display("%s", msg);
  endtask

  task automatic finish_test(input string name, input int err_before);
    tests++;
    $display("test %-14s done, %0d errors", name, errors - err_before);
  endtask

  `include "tb_board_tests.svh"

  ////////////////////////////////////////////////////////////////////////////
  // clock, sequence and watchdog
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    soc_clk = 1'b0;
    forever #(ClkPeriod / 2) soc_clk = ~soc_clk;
  end

  initial begin
    void'($urandom(97));
    rst_n         = 1'b0;
    soft_reset_i  = 1'b0;
    fan_sw_i      = '0;
    spih_sck_i    = 1'b0;
    spih_sck_en_i = 1'b0;
    spih_csb_i    = '1;
    spih_csb_en_i = '0;
    spih_sd_i     = '0;
    spih_sd_en_i  = '0;
    sd_dat0_i     = 1'b0;
    qspi_dq0_i    = 1'b0;
    repeat (16) @(posedge soc_clk);
    test_reset_release();
    test_rtc();
    test_fan_pwm();
    test_sd_pins();
    test_qspi_pins();
    $display("tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // bound from the test lengths plus some slack
  initial begin
    #((RunCycles + 50) * ClkPeriod);
    $display("watchdog expired after %0d cycles, tests did not finish", RunCycles + 50);
    $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire
